// ==== hdl/prf_settings.svh ====
/*
 * physical register file sizing
 * entry count, value width, reserved zero entry and thread count
 */

`ifndef PRF_SETTINGS_SVH
`define PRF_SETTINGS_SVH

////////////////////
// register file shape
////////////////////

`define PRF_SIZE     64   // number of physical registers
`define PRF_DATA_W   64   // width of one register value
`define PRF_IDX_W    6    // index width, log2 of the entry count

// this entry is held busy, ready and zero from reset on and is never handed out
`define PRF_ZERO_IDX 48

// two rename tables share the file
`define PRF_THREADS  2

`endif

// ==== hdl/rename_pkg.sv ====
/*
 * rename side types of the physical register file
 * allocation requests and grants, operand read requests and responses
 */

`default_nettype none

`include "prf_settings.svh"

package rename_pkg;

	typedef logic [`PRF_IDX_W-1:0]  prf_idx_t;   // one physical register index
	typedef logic [`PRF_DATA_W-1:0] prf_data_t;  // one register value
	typedef logic [`PRF_SIZE-1:0]   prf_mask_t;  // one bit per physical entry

	////////////////////
	// allocation
	////////////////////

	// a thread asks for up to two new entries per cycle
	typedef struct packed {
		logic slot1;  // first destination of the pair needs an entry
		logic slot2;  // second destination of the pair needs an entry
	} alloc_req_t;

	// answer for one slot of one thread
	typedef struct packed {
		logic     valid;  // low when the thread lost arbitration or the file is full
		prf_idx_t idx;
	} alloc_gnt_t;

	////////////////////
	// operand read
	////////////////////

	// source indices of the two instructions renamed together
	typedef struct packed {
		prf_idx_t inst1_opa;
		prf_idx_t inst1_opb;
		prf_idx_t inst2_opa;
		prf_idx_t inst2_opb;
	} operand_req_t;

	// tag view of an operand word, index sits in the low bits
	typedef struct packed {
		logic [`PRF_DATA_W-`PRF_IDX_W-1:0] pad;  // always zero
		prf_idx_t                         idx;
	} operand_tag_t;

	// a ready operand carries its value, a pending one carries its own tag
	typedef union packed {
		prf_data_t    value;
		operand_tag_t tag;
	} operand_word_u;

	typedef struct packed {
		logic          valid;  // high means word holds the value
		operand_word_u word;
	} operand_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/commit_pkg.sv ====
/*
 * commit side types of the physical register file
 * CDB results, retire frees and branch mispredict recovery lists
 */

`default_nettype none

package commit_pkg;

	import rename_pkg::*;

	// one result broadcast on the common data bus
	typedef struct packed {
		logic      valid;
		prf_idx_t  tag;   // destination entry of the result
		prf_data_t data;
	} cdb_wr_t;

	// a retiring instruction releases the entry its destination held before
	typedef struct packed {
		logic     valid;
		prf_idx_t idx;
	} free_req_t;

	////////////////////
	// mispredict recovery
	////////////////////

	// an entry may only be released if neither thread still maps it,
	// so the recovering thread's RRAT list travels with the other thread's RAT list
	typedef struct packed {
		logic      valid;
		prf_mask_t rrat_list;       // entries the recovering thread's RRAT gives up
		prf_mask_t other_rat_list;  // entries the other thread's RAT does not map
	} recovery_t;

endpackage

`default_nettype wire

// ==== hdl/prf_entry_array.sv ====
/*
 * physical register storage
 * per entry free and ready state plus the register value,
 * updated by allocation, CDB writeback and freeing
 */

`timescale 1ns/1ps
`default_nettype none

`include "prf_settings.svh"

module prf_entry_array (
	input  wire logic                                    clock,
	input  wire logic                                    rst_n,
	input  wire rename_pkg::prf_mask_t                   alloc_mask,  // one hot per granted slot
	input  wire rename_pkg::prf_mask_t                   free_mask,
	input  wire commit_pkg::cdb_wr_t [1:0]               cdb,
	output rename_pkg::prf_mask_t                        available,   // entry is on the free list
	output rename_pkg::prf_mask_t                        ready,       // entry holds its result
	output wire rename_pkg::prf_data_t [`PRF_SIZE-1:0]   entry_data
);

	import rename_pkg::*;

	localparam prf_mask_t zero_bit = prf_mask_t'(1) << `PRF_ZERO_IDX;

	prf_mask_t                     wr_en;    // entry is written by a CDB this cycle
	prf_data_t [`PRF_SIZE-1:0]     wr_data;
	prf_mask_t                     free_eff; // frees with the zero entry dropped

	////////////////////
	// CDB decode
	////////////////////

	always_comb
	begin
		wr_en   = '0;
		wr_data = '0;
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			for (int p = 0; p < 2; p++)  // the second bus wins on a shared tag
			begin
				if (cdb[p].valid && (cdb[p].tag == prf_idx_t'(i)))
				begin
					wr_en[i]   = 1'b1;
					wr_data[i] = cdb[p].data;
				end
			end
		end
		wr_en = wr_en & ~zero_bit;  // the zero entry keeps its value
	end

	assign free_eff = free_mask & ~zero_bit;

	// allocation beats a free of the same entry, the grant has already gone out
	// a free beats a write so a squashed result cannot mark a released entry ready
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			available <= ~zero_bit;  // everything free except the zero entry
			ready     <= zero_bit;   // only the zero entry reads as valid
		end
		else
		begin
			available <= (available | free_eff) & ~alloc_mask;
			ready     <= (ready | wr_en) & ~free_eff & ~alloc_mask;
		end
	end

	////////////////////
	// value storage
	////////////////////

	for (genvar i = 0; i < `PRF_SIZE; i++)
	begin : g_entry
		if (i == `PRF_ZERO_IDX)
		begin : g_zero
			assign entry_data[i] = '0;  // no storage, the value is a constant
		end
		else
		begin : g_data
			prf_data_t data_q;

			always_ff @(posedge clock)
			begin
				if (wr_en[i])
				begin
					data_q <= wr_data[i];
				end
			end

			assign entry_data[i] = data_q;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/prf_allocator.sv ====
/*
 * rename allocation
 * round-robin choice between the two threads and two lowest-index
 * free entry pickers, combinational grants in the request cycle
 */

`timescale 1ns/1ps
`default_nettype none

`include "prf_settings.svh"

module prf_allocator (
	input  wire logic                                          clock,
	input  wire logic                                          rst_n,
	input  wire rename_pkg::prf_mask_t                         available,
	input  wire rename_pkg::alloc_req_t [`PRF_THREADS-1:0]     thread_req,
	output rename_pkg::alloc_gnt_t [2*`PRF_THREADS-1:0]        thread_gnt,  // thread*2 + slot
	output rename_pkg::prf_mask_t                              alloc_mask,
	output logic                                               prf_full
);

	import rename_pkg::*;

	logic                    rr_ptr;      // favored thread on a contested cycle, 0 is thread 1
	logic [`PRF_THREADS-1:0] req_any;
	logic                    contested;
	logic                    gnt_thread;  // thread served this cycle
	alloc_req_t              sel_req;
	alloc_gnt_t              pick1;       // lowest free entry
	alloc_gnt_t              pick2;       // next lowest free entry
	prf_mask_t               pick1_bit;
	prf_mask_t               pick2_bit;

	// lowest set bit of the mask as an index, valid low when the mask is empty
	function automatic alloc_gnt_t lowest_free(input prf_mask_t mask);
		alloc_gnt_t pick;
		pick = '0;
		for (int i = `PRF_SIZE - 1; i >= 0; i--)  // scan down so the lowest hit is kept
		begin
			if (mask[i])
			begin
				pick.valid = 1'b1;
				pick.idx   = prf_idx_t'(i);
			end
		end
		return pick;
	endfunction

	////////////////////
	// thread arbiter
	////////////////////

	for (genvar t = 0; t < `PRF_THREADS; t++)
	begin : g_req
		assign req_any[t] = thread_req[t].slot1 | thread_req[t].slot2;
	end

	assign contested  = &req_any;
	assign gnt_thread = contested ? rr_ptr : req_any[1];  // a lone request always wins
	assign sel_req    = thread_req[gnt_thread];           // all zero when nobody asks

	// pointer moves after every contested cycle, whether or not entries were left
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rr_ptr <= 1'b0;
		end
		else if (contested)
		begin
			rr_ptr <= ~rr_ptr;
		end
	end

	////////////////////
	// entry pickers
	////////////////////

	assign pick1     = lowest_free(available);
	assign pick1_bit = pick1.valid ? (prf_mask_t'(1) << pick1.idx) : '0;
	assign pick2     = lowest_free(available & ~pick1_bit);  // second picker skips the first hit
	assign pick2_bit = pick2.valid ? (prf_mask_t'(1) << pick2.idx) : '0;

	always_comb
	begin
		thread_gnt = '0;
		alloc_mask = '0;
		if (sel_req.slot1)
		begin
			thread_gnt[{gnt_thread, 1'b0}] = pick1;
			alloc_mask                     = pick1_bit;
			if (sel_req.slot2)
			begin
				thread_gnt[{gnt_thread, 1'b1}] = pick2;  // pair gets the next lowest
				alloc_mask                     = alloc_mask | pick2_bit;
			end
		end
		else if (sel_req.slot2)
		begin
			// a lone slot2 request is still served from the lowest entry
			thread_gnt[{gnt_thread, 1'b1}] = pick1;
			alloc_mask                     = pick1_bit;
		end
	end

	assign prf_full = ~|available;  // no free entry left for any thread

endmodule

`default_nettype wire

// ==== hdl/prf_free_ctrl.sv ====
/*
 * free mask builder
 * merges the four retire frees and both mispredict recovery lists
 * into one per-entry release mask for the next edge
 */

`timescale 1ns/1ps
`default_nettype none

module prf_free_ctrl (
	input  wire commit_pkg::free_req_t [3:0]   free_req,  // two per thread from the RRATs
	input  wire commit_pkg::recovery_t [1:0]   recovery,  // one per thread
	output rename_pkg::prf_mask_t              free_mask
);

	always_comb
	begin
		free_mask = '0;

		// retire frees, each names a single entry
		for (int k = 0; k < 4; k++)
		begin
			if (free_req[k].valid)
			begin
				free_mask[free_req[k].idx] = 1'b1;
			end
		end

		// recovery releases only entries neither thread still maps
		// both conditions simply add to the retire frees
		for (int t = 0; t < 2; t++)
		begin
			if (recovery[t].valid)
			begin
				free_mask = free_mask | (recovery[t].rrat_list & recovery[t].other_rat_list);
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/prf_operand_read.sv ====
/*
 * operand and retire read ports
 * four source reads for the selected thread, value or tag through the
 * operand union, and two retire reads of committed values
 */

`timescale 1ns/1ps
`default_nettype none

`include "prf_settings.svh"

module prf_operand_read (
	input  wire logic                                         read_thread,  // 0 serves thread 1
	input  wire rename_pkg::operand_req_t [`PRF_THREADS-1:0]  operand_req,
	input  wire rename_pkg::prf_idx_t [1:0]                   retire_idx,
	input  wire rename_pkg::prf_mask_t                        available,
	input  wire rename_pkg::prf_mask_t                        ready,
	input  wire rename_pkg::prf_data_t [`PRF_SIZE-1:0]        entry_data,
	output rename_pkg::operand_rsp_t [3:0]                    operand_rsp,
	output rename_pkg::prf_data_t [1:0]                       retire_data
);

	import rename_pkg::*;

	operand_req_t   sel;       // indices of the thread being read
	prf_idx_t [3:0] src_idx;   // 0 inst1 opa, 1 inst1 opb, 2 inst2 opa, 3 inst2 opb
	prf_mask_t      usable;    // allocated and holding its result

	assign sel     = operand_req[read_thread];
	assign src_idx = {sel.inst2_opb, sel.inst2_opa, sel.inst1_opb, sel.inst1_opa};
	assign usable  = ready & ~available;  // the zero entry is always in here

	////////////////////
	// source operands
	////////////////////

	always_comb
	begin
		for (int k = 0; k < 4; k++)
		begin
			operand_rsp[k].valid = usable[src_idx[k]];
			if (usable[src_idx[k]])
			begin
				operand_rsp[k].word.value = entry_data[src_idx[k]];
			end
			else
			begin
				// pending source, the consumer waits for this tag on the CDB
				operand_rsp[k].word.tag.pad = '0;
				operand_rsp[k].word.tag.idx = src_idx[k];
			end
		end
	end

	////////////////////
	// retire reads
	////////////////////

	always_comb
	begin
		for (int r = 0; r < 2; r++)
		begin
			// an entry without a result reads as zero
			retire_data[r] = usable[retire_idx[r]] ? entry_data[retire_idx[r]] : '0;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/prf_top.sv ====
/*
 * physical register file of a two-thread out-of-order core
 * rename allocation, CDB writeback, operand and retire reads, freeing
 */

`timescale 1ns/1ps
`default_nettype none

`include "prf_settings.svh"

module prf_top (
	input  wire logic                                          clock,
	input  wire logic                                          rst_n,

	// rename allocation, index 0 is thread 1
	input  wire rename_pkg::alloc_req_t [`PRF_THREADS-1:0]     alloc_req,
	output rename_pkg::alloc_gnt_t [2*`PRF_THREADS-1:0]        alloc_gnt,  // thread*2 + slot
	output logic                                               prf_full,

	// writeback
	input  wire commit_pkg::cdb_wr_t [1:0]                     cdb,

	// operand read for the thread picked by read_thread
	input  wire rename_pkg::operand_req_t [`PRF_THREADS-1:0]   operand_req,
	input  wire logic                                          read_thread,
	output rename_pkg::operand_rsp_t [3:0]                     operand_rsp,

	// retire side
	input  wire commit_pkg::free_req_t [3:0]                   free_req,
	input  wire commit_pkg::recovery_t [`PRF_THREADS-1:0]      recovery,
	input  wire rename_pkg::prf_idx_t [1:0]                    retire_idx,
	output rename_pkg::prf_data_t [1:0]                        retire_data
);

	import rename_pkg::*;

	prf_mask_t                 available;   // free list state of every entry
	prf_mask_t                 ready;
	prf_data_t [`PRF_SIZE-1:0] entry_data;
	prf_mask_t                 alloc_mask;  // entries granted this cycle
	prf_mask_t                 free_mask;   // entries released at the next edge

	////////////////////
	// storage and update
	////////////////////

	prf_entry_array prf_entry_array_inst (
		.clock      (clock),
		.rst_n      (rst_n),
		.alloc_mask (alloc_mask),
		.free_mask  (free_mask),
		.cdb        (cdb),
		.available  (available),
		.ready      (ready),
		.entry_data (entry_data)
	);

	prf_allocator prf_allocator_inst (
		.clock      (clock),
		.rst_n      (rst_n),
		.available  (available),
		.thread_req (alloc_req),
		.thread_gnt (alloc_gnt),
		.alloc_mask (alloc_mask),
		.prf_full   (prf_full)
	);

	prf_free_ctrl prf_free_ctrl_inst (
		.free_req  (free_req),
		.recovery  (recovery),
		.free_mask (free_mask)
	);

	////////////////////
	// read ports
	////////////////////

	prf_operand_read prf_operand_read_inst (
		.read_thread (read_thread),
		.operand_req (operand_req),
		.retire_idx  (retire_idx),
		.available   (available),
		.ready       (ready),
		.entry_data  (entry_data),
		.operand_rsp (operand_rsp),
		.retire_data (retire_data)
	);

endmodule

`default_nettype wire

// ==== dv/prf_tb_tasks.svh ====
/*
 * stimulus tasks of the register file testbench
 * each task drives one cycle of inputs on the rising clock edge
 */

`ifndef PRF_TB_TASKS_SVH
`define PRF_TB_TASKS_SVH

// pulse inputs fall back to idle unless the calling task sets them again
task automatic drop_strobes();
	alloc_req <= '0;
	cdb       <= '0;
	free_req  <= '0;
	recovery  <= '0;
endtask

task automatic idle_cycle();
	@(posedge clock);
	drop_strobes();
endtask

task automatic alloc_cycle(input alloc_req_t t1_req, input alloc_req_t t2_req);
	@(posedge clock);
	drop_strobes();
	alloc_req <= {t2_req, t1_req};  // index 0 is thread 1
endtask

// two results in one cycle with one on each bus
task automatic cdb_cycle(input prf_idx_t tag_a, input prf_data_t data_a,
	input prf_idx_t tag_b, input prf_data_t data_b);
	@(posedge clock);
	drop_strobes();
	cdb[0] <= '{1'b1, tag_a, data_a};
	cdb[1] <= '{1'b1, tag_b, data_b};
endtask

// source indices and thread select are levels and stay until changed
task automatic read_setup(input logic thread, input operand_req_t t1_srcs,
	input operand_req_t t2_srcs);
	@(posedge clock);
	drop_strobes();
	operand_req <= {t2_srcs, t1_srcs};
	read_thread <= thread;  // 0 reads thread 1
endtask

// two retire reads with one free from each thread's RRAT
task automatic retire_cycle(input prf_idx_t read_a, input prf_idx_t read_b,
	input prf_idx_t free_a, input prf_idx_t free_b);
	@(posedge clock);
	drop_strobes();
	retire_idx  <= {read_b, read_a};
	free_req[0] <= '{1'b1, free_a};
	free_req[2] <= '{1'b1, free_b};
endtask

// four retire frees in one cycle with one on every free port
task automatic free_cycle(input prf_idx_t free_0, input prf_idx_t free_1,
	input prf_idx_t free_2, input prf_idx_t free_3);
	@(posedge clock);
	drop_strobes();
	free_req[0] <= '{1'b1, free_0};
	free_req[1] <= '{1'b1, free_1};
	free_req[2] <= '{1'b1, free_2};
	free_req[3] <= '{1'b1, free_3};
endtask

task automatic recovery_cycle(input recovery_t t1_rec, input recovery_t t2_rec);
	@(posedge clock);
	drop_strobes();
	recovery <= {t2_rec, t1_rec};
endtask

////////////////////
// waits
////////////////////

// thread 1 keeps asking for pairs until the file reports full
task automatic fill_until_full();
	int cycles;
	cycles = 0;
	@(negedge clock);
	while (!prf_full)
	begin
		if (cycles > `PRF_SIZE)  // each cycle takes up to two entries
		begin
			fail_run("prf_full did not rise while allocating every free entry");
		end
		else
		begin
			alloc_cycle(2'b11, 2'b00);
			cycles++;
			@(negedge clock);
		end
	end
	idle_cycle();  // the last request met a full file
endtask

`endif

// ==== dv/tb_prf_top.sv ====
/*
 * testbench for the physical register file
 * keeps a reference copy of the free, ready and data state and
 * compares every DUT output against it with concurrent assertions
 */

`timescale 1ns/1ps
`default_nettype none

`include "prf_settings.svh"

module tb_prf_top;

	import rename_pkg::*;
	import commit_pkg::*;

	localparam prf_mask_t  zero_bit   = prf_mask_t'(1) << `PRF_ZERO_IDX;
	localparam alloc_req_t no_req     = 2'b00;
	localparam alloc_req_t want_both  = 2'b11;
	localparam alloc_req_t want_slot2 = 2'b01;

	logic                                clock;
	logic                                rst_n;
	alloc_req_t   [`PRF_THREADS-1:0]     alloc_req;
	alloc_gnt_t   [2*`PRF_THREADS-1:0]   alloc_gnt;
	logic                                prf_full;
	cdb_wr_t      [1:0]                  cdb;
	operand_req_t [`PRF_THREADS-1:0]     operand_req;
	logic                                read_thread;
	operand_rsp_t [3:0]                  operand_rsp;
	free_req_t    [3:0]                  free_req;
	recovery_t    [`PRF_THREADS-1:0]     recovery;
	prf_idx_t     [1:0]                  retire_idx;
	prf_data_t    [1:0]                  retire_data;

	prf_mask_t                 ref_free;    // reference free list
	prf_mask_t                 ref_ready;
	prf_data_t [`PRF_SIZE-1:0] ref_data;
	logic                      ref_rr;      // thread favored on the next contested cycle
	alloc_gnt_t   [3:0]        exp_gnt;
	prf_mask_t                 exp_take;    // entries the expected grants hand out
	operand_rsp_t [3:0]        exp_rsp;
	prf_data_t    [1:0]        exp_retire;

	prf_top prf_top_inst (
		.clock       (clock),
		.rst_n       (rst_n),
		.alloc_req   (alloc_req),
		.alloc_gnt   (alloc_gnt),
		.prf_full    (prf_full),
		.cdb         (cdb),
		.operand_req (operand_req),
		.read_thread (read_thread),
		.operand_rsp (operand_rsp),
		.free_req    (free_req),
		.recovery    (recovery),
		.retire_idx  (retire_idx),
		.retire_data (retire_data)
	);

	always #4 clock = ~clock;  // 8 ns period

	// prints the reason and stops the run
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		fail_run($sformatf("CHECK FAILED time %0t %s expected %0h got %0h",
			$time, name, expected, actual));
	endtask

	// lowest free entry outside skip or -1 when none is left
	function automatic int lowest_free_idx(input prf_mask_t free, input prf_mask_t skip);
		int found;
		found = -1;
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			if (found < 0 && free[i] && !skip[i])
			begin
				found = i;
			end
		end
		return found;
	endfunction

	function automatic alloc_gnt_t grant_of(input int idx);
		alloc_gnt_t g;
		g = '0;  // no entry means valid low and index zero
		if (idx >= 0)
		begin
			g.valid = 1'b1;
			g.idx   = prf_idx_t'(idx);
		end
		return g;
	endfunction

	function automatic bit gives_zero_entry(input alloc_gnt_t [3:0] g);
		bit hit;
		hit = 1'b0;
		for (int k = 0; k < 4; k++)
		begin
			hit |= g[k].valid && (g[k].idx == prf_idx_t'(`PRF_ZERO_IDX));
		end
		return hit;
	endfunction

	////////////////////
	// expected outputs
	////////////////////

	always_comb
	begin
		logic [1:0] asks;
		int         w;
		int         first;
		int         second;
		asks[0] = |alloc_req[0];
		asks[1] = |alloc_req[1];
		w       = (&asks) ? int'(ref_rr) : int'(asks[1]);  // a lone requester always wins
		first   = lowest_free_idx(ref_free, '0);
		second  = -1;
		if (first >= 0)
		begin
			second = lowest_free_idx(ref_free, prf_mask_t'(1) << first);
		end
		exp_gnt = '0;
		if (alloc_req[w].slot1)
		begin
			exp_gnt[2*w] = grant_of(first);
			if (alloc_req[w].slot2)
			begin
				exp_gnt[2*w+1] = grant_of(second);
			end
		end
		else if (alloc_req[w].slot2)
		begin
			exp_gnt[2*w+1] = grant_of(first);  // slot2 alone still takes the lowest
		end
		exp_take = '0;
		for (int k = 0; k < 4; k++)
		begin
			if (exp_gnt[k].valid)
			begin
				exp_take[exp_gnt[k].idx] = 1'b1;
			end
		end
	end

	always_comb
	begin
		operand_req_t   sel;
		prf_idx_t [3:0] src;
		prf_mask_t      usable;
		sel    = operand_req[read_thread];
		src    = {sel.inst2_opb, sel.inst2_opa, sel.inst1_opb, sel.inst1_opa};
		usable = ref_ready & ~ref_free;  // allocated and written
		for (int k = 0; k < 4; k++)
		begin
			exp_rsp[k].valid      = usable[src[k]];
			exp_rsp[k].word.value = usable[src[k]] ? ref_data[src[k]] : prf_data_t'(src[k]);
		end
		for (int r = 0; r < 2; r++)
		begin
			exp_retire[r] = usable[retire_idx[r]] ? ref_data[retire_idx[r]] : '0;
		end
	end

	////////////////////
	// reference state
	////////////////////

	always @(posedge clock or negedge rst_n)
	begin
		prf_mask_t released;
		prf_mask_t written;
		if (!rst_n)
		begin
			ref_free  <= ~zero_bit;
			ref_ready <= zero_bit;
			ref_data  <= '0;
			ref_rr    <= 1'b0;
		end
		else
		begin
			released = '0;
			for (int k = 0; k < 4; k++)
			begin
				if (free_req[k].valid)
				begin
					released[free_req[k].idx] = 1'b1;
				end
			end
			for (int t = 0; t < 2; t++)
			begin
				if (recovery[t].valid)
				begin
					released |= recovery[t].rrat_list & recovery[t].other_rat_list;
				end
			end
			released &= ~zero_bit;
			written = '0;
			for (int p = 0; p < 2; p++)  // port 1 is assigned last and wins a shared tag
			begin
				if (cdb[p].valid && cdb[p].tag != prf_idx_t'(`PRF_ZERO_IDX))
				begin
					written[cdb[p].tag]  = 1'b1;
					ref_data[cdb[p].tag] <= cdb[p].data;
				end
			end
			ref_free  <= (ref_free | released) & ~exp_take;
			ref_ready <= (ref_ready | written) & ~released & ~exp_take;
			if ((|alloc_req[0]) && (|alloc_req[1]))
			begin
				ref_rr <= ~ref_rr;
			end
		end
	end

	////////////////////
	// checks
	////////////////////

	a_grant: assert property (@(negedge clock) disable iff (!rst_n) alloc_gnt == exp_gnt)
		else report_mismatch("alloc_gnt", 128'(exp_gnt), 128'(alloc_gnt));
	a_full: assert property (@(negedge clock) disable iff (!rst_n) prf_full == (ref_free == '0))
		else report_mismatch("prf_full", 128'(ref_free == '0), 128'(prf_full));
	a_zero_kept: assert property (@(negedge clock) disable iff (!rst_n)
		!gives_zero_entry(alloc_gnt))
		else fail_run("the zero entry was handed out by the allocator");

	for (genvar k = 0; k < 4; k++)
	begin : g_operand_check
		a_operand: assert property (@(negedge clock) disable iff (!rst_n)
			operand_rsp[k] == exp_rsp[k])
			else report_mismatch($sformatf("operand_rsp[%0d]", k), 128'(exp_rsp[k]),
				128'(operand_rsp[k]));
	end

	for (genvar r = 0; r < 2; r++)
	begin : g_retire_check
		a_retire: assert property (@(negedge clock) disable iff (!rst_n)
			retire_data[r] == exp_retire[r])
			else report_mismatch($sformatf("retire_data[%0d]", r), 128'(exp_retire[r]),
				128'(retire_data[r]));
	end

	`include "prf_tb_tasks.svh"

	initial
	begin
		recovery_t [1:0] rec;
		prf_data_t       d0;
		prf_data_t       d1;
		void'($urandom(42));
		clock       = 1'b0;
		rst_n       = 1'b0;
		alloc_req   = '0;
		cdb         = '0;
		operand_req = '0;
		read_thread = 1'b0;
		free_req    = '0;
		recovery    = '0;
		retire_idx  = '0;
		repeat (5) @(posedge clock);
		rst_n <= 1'b1;

		// a thread 1 pair right after reset and then a fill of the whole file
		alloc_cycle(want_both, no_req);
		@(negedge clock);
		a_first_pair: assert (alloc_gnt[0] == alloc_gnt_t'({1'b1, 6'd0})
			&& alloc_gnt[1] == alloc_gnt_t'({1'b1, 6'd1}))
			else report_mismatch("alloc_gnt thread 1", 128'({7'h41, 7'h40}),
				128'({alloc_gnt[1], alloc_gnt[0]}));
		fill_until_full();

		// pending sources read as tags while both CDB ports fire together
		read_setup(1'b0, operand_req_t'({6'd2, 6'd3, 6'd48, 6'd7}),
			operand_req_t'({6'd48, 6'd9, 6'd10, 6'd48}));
		d0 = prf_data_t'({$urandom, $urandom});
		d1 = prf_data_t'({$urandom, $urandom});
		cdb_cycle(6'd2, d0, 6'd3, d1);
		idle_cycle();
		@(negedge clock);
		a_zero_read: assert (operand_rsp[2].valid && operand_rsp[2].word.value == '0)
			else report_mismatch("operand_rsp[2]", 128'({1'b1, 64'h0}),
				128'(operand_rsp[2]));
		read_setup(1'b1, operand_req_t'({6'd2, 6'd3, 6'd48, 6'd7}),
			operand_req_t'({6'd48, 6'd9, 6'd10, 6'd48}));
		cdb_cycle(6'd9, prf_data_t'({$urandom, $urandom}), 6'd10,
			prf_data_t'({$urandom, $urandom}));
		idle_cycle();

		// retire reads and then a freed entry comes back as the lowest one
		retire_cycle(6'd2, 6'd3, 6'd3, 6'd10);
		@(negedge clock);
		a_retire_value: assert (retire_data[0] == d0)
			else report_mismatch("retire_data[0]", 128'(d0), 128'(retire_data[0]));
		alloc_cycle(no_req, want_slot2);
		idle_cycle();

		// free eight entries over all four ports and let both threads keep asking for pairs
		free_cycle(6'd20, 6'd21, 6'd22, 6'd23);
		free_cycle(6'd24, 6'd25, 6'd26, 6'd27);
		repeat (5) alloc_cycle(want_both, want_both);
		idle_cycle();

		// each round of random recovery lists is followed by a refill of whatever got released
		for (int round = 0; round < 4; round++)
		begin
			for (int t = 0; t < 2; t++)
			begin
				// rounds 0 and 1 recover one thread each while the other sends lists without valid
				rec[t].valid          = (round < 2) ? (round == t) : (($urandom & 1) != 0);
				rec[t].rrat_list      = prf_mask_t'({$urandom, $urandom});
				rec[t].other_rat_list = prf_mask_t'({$urandom, $urandom});
			end
			recovery_cycle(rec[0], rec[1]);
			idle_cycle();
			fill_until_full();
		end

		idle_cycle();
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hdl
+incdir+dv
hdl/rename_pkg.sv
hdl/commit_pkg.sv
hdl/prf_entry_array.sv
hdl/prf_allocator.sv
hdl/prf_free_ctrl.sv
hdl/prf_operand_read.sv
hdl/prf_top.sv
dv/tb_prf_top.sv

// ==== run.sh ====
#!/bin/sh
# build the register file testbench with Verilator, run it and check the log
set -e

verilator --binary --assert -j 0 --top-module tb_prf_top -f vlog.f -o tb_prf_top

# the run exits nonzero on failure, the log search below decides the result
./obj_dir/tb_prf_top > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log
then
	echo "simulation reported a failure"
	exit 1
fi
grep -q '\*\* PASS \*\*' sim.log
